/* hw/optical_rx_pkg.sv */
`default_nettype none

package optical_rx_pkg;

  //----------------------------------------------------------------------
  // Link word and frame types
  //----------------------------------------------------------------------
  localparam int WORDS_PER_FRAME = 4;              // Header word plus three data words

  typedef logic [15:0] word_t;                     // One deserialized link word

  // Three data words, first received word in the high bits
  typedef logic [(WORDS_PER_FRAME-1)*16-1:0] frame_data_t;

  typedef logic [15:0] frame_kchar_t;              // K-character header of a frame

  //----------------------------------------------------------------------
  // Header codes, always sent with the K flag
  //----------------------------------------------------------------------
  localparam word_t HDR_START = 16'h50BC;          // Start or idle pattern
  localparam word_t HDR_FC    = 16'h50FC;          // Latency trigger marker

  //----------------------------------------------------------------------
  // Widths and defaults
  //----------------------------------------------------------------------
  localparam int ERR_COUNT_W = 16;                 // Link and PRBS error counters

  localparam int DEFAULT_LT_PERIOD   = 128;        // Frames between FC headers
  localparam int DEFAULT_GOOD_FRAMES = 4;          // Clean frames before link good

  localparam int DELAY_DEPTH = 16;                 // Output delay, 0 to 15 bx

endpackage

`default_nettype wire

/* hw/bx_delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module bx_delay_line import optical_rx_pkg::*; #(
  parameter type payload_t = frame_data_t         // Frame data or header
) (
  input  logic       clock,
  input  logic       shift_en,                    // One shift per frame
  input  logic [3:0] delay_is,                    // Tap select, 0 is newest
  input  payload_t   din,
  output payload_t   dout
);

  payload_t sr [DELAY_DEPTH];                     // Entry 0 holds the latest frame

  //----------------------------------------------------------------------
  // Shift register with addressable tap
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (shift_en) begin
      sr[0] <= din;
      for (int i = 1; i < DELAY_DEPTH; i++) begin
        sr[i] <= sr[i-1];
      end
    end
  end

  assign dout = sr[delay_is];                     // Tap read, no added latency

endmodule

`default_nettype wire

/* hw/frame_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_assembler import optical_rx_pkg::*; #(
  parameter bit POL_SWAP = 1'b0                   // Fiber has swapped board route
) (
  input  logic         clock,
  input  logic         gtx_rx_reset,
  input  word_t        rx_word,
  input  logic         rx_kflag,
  output logic         frame_valid,
  output logic         link_error,
  output frame_data_t  frame_data,
  output frame_kchar_t frame_kchar,
  output logic         locked
);

  localparam int PHASE_W = $clog2(WORDS_PER_FRAME);
  localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(WORDS_PER_FRAME - 1);
  localparam int WORD_W = $bits(word_t);
  localparam int HOLD_W = $bits(frame_data_t) - WORD_W;  // Data words before the last

  word_t              word_c;                     // Polarity corrected word
  logic               kflag_c;
  logic               hdr_ok;                     // Valid K header on this word
  logic [PHASE_W-1:0] phase;                      // Word position inside the frame
  frame_kchar_t       kchar_hold;
  logic [HOLD_W-1:0]  data_hold;

  //----------------------------------------------------------------------
  // Polarity correction and header decode
  //----------------------------------------------------------------------
  assign word_c  = POL_SWAP ? ~rx_word  : rx_word;
  assign kflag_c = POL_SWAP ? ~rx_kflag : rx_kflag;
  assign hdr_ok  = kflag_c && ((word_c == HDR_START) || (word_c == HDR_FC));

  //----------------------------------------------------------------------
  // Hunt and lock FSM with phase counter
  //----------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      locked      <= 1'b0;
      phase       <= '0;
      frame_valid <= 1'b0;
      link_error  <= 1'b0;
    end else begin
      frame_valid <= 1'b0;                        // Single cycle strobes
      link_error  <= 1'b0;
      if (!locked) begin
        if (hdr_ok) begin                         // Header found, this word is phase 0
          locked <= 1'b1;
          phase  <= PHASE_W'(1);
        end
      end else if (phase == '0) begin
        if (hdr_ok) begin
          phase <= PHASE_W'(1);
        end else begin                            // Lost framing on the header slot
          link_error <= 1'b1;
          locked     <= 1'b0;
        end
      end else if (kflag_c) begin                 // K flag where data belongs
        link_error <= 1'b1;
        locked     <= 1'b0;
        phase      <= '0;
      end else if (phase == LAST_PHASE) begin
        frame_valid <= 1'b1;                      // Frame complete
        phase       <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // Word collection
  always_ff @(posedge clock) begin
    if (hdr_ok && (!locked || (phase == '0))) begin
      kchar_hold <= word_c;                       // Header of the frame in progress
    end
    if (locked && (phase != '0) && (phase != LAST_PHASE)) begin
      data_hold <= {data_hold[HOLD_W-WORD_W-1:0], word_c};
    end
    if (locked && (phase == LAST_PHASE)) begin
      frame_data  <= {data_hold, word_c};         // First word lands in the high bits
      frame_kchar <= kchar_hold;
    end
  end

  // At most one frame per four words
  a_frame_valid_gap : assert property (
    @(posedge clock) disable iff (gtx_rx_reset) frame_valid |=> !frame_valid
  );

endmodule

`default_nettype wire

/* hw/link_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module link_monitor import optical_rx_pkg::*; #(
  parameter int GOOD_FRAMES = DEFAULT_GOOD_FRAMES // Clean frames needed for link good
) (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  logic                   ttc_resync,
  input  logic                   frame_valid,
  input  logic                   link_error,
  input  logic                   force_error,
  output logic [ERR_COUNT_W-1:0] errcount,
  output logic                   link_had_err,
  output logic                   link_good,
  output logic                   link_bad
);

  localparam int BAD_LIMIT = 8;                   // Errors that mark a link bad
  localparam int GOOD_W    = $clog2(GOOD_FRAMES + 1);

  logic                   any_err;
  logic [ERR_COUNT_W:0]   err_sum;                // One extra bit catches the carry
  logic [GOOD_W-1:0]      good_cnt;               // Consecutive clean frames

  assign any_err  = link_error | force_error;
  assign err_sum  = {1'b0, errcount} + link_error + force_error;
  assign link_bad = (errcount >= ERR_COUNT_W'(BAD_LIMIT));

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      errcount     <= '0;
      link_had_err <= 1'b0;
      link_good    <= 1'b0;
      good_cnt     <= '0;
    end else if (ttc_resync) begin                // Resync starts a fresh link history
      errcount     <= '0;
      link_had_err <= 1'b0;
      link_good    <= 1'b0;
      good_cnt     <= '0;
    end else if (any_err) begin
      errcount     <= err_sum[ERR_COUNT_W] ? '1 : err_sum[ERR_COUNT_W-1:0];  // Saturate
      link_had_err <= 1'b1;                       // Sticky
      link_good    <= 1'b0;
      good_cnt     <= '0;
    end else if (frame_valid && !link_good) begin
      if (good_cnt == GOOD_W'(GOOD_FRAMES - 1)) begin
        link_good <= !link_bad;                   // A bad link never turns good
      end else begin
        good_cnt <= good_cnt + 1'b1;
      end
    end
  end

  // The error threshold and the clean-frame qualifier must agree
  a_good_bad_exclusive : assert property (
    @(posedge clock) disable iff (gtx_rx_reset) !(link_good && link_bad)
  );

endmodule

`default_nettype wire

/* hw/prbs_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module prbs_checker import optical_rx_pkg::*; (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  logic                   ttc_resync,
  input  logic                   enable,
  input  logic                   frame_valid,
  input  frame_data_t            frame_data,
  output logic                   match,
  output logic                   err,
  output logic [ERR_COUNT_W-1:0] err_count
);

  frame_data_t prev_frame;                        // Last frame received under test
  frame_data_t expected;
  logic        feedback;
  logic        seeded;

  // Fibonacci LFSR, taps 48 47 21 20, new bit into bit 0
  assign feedback = prev_frame[47] ^ prev_frame[46] ^ prev_frame[20] ^ prev_frame[19];
  assign expected = {prev_frame[46:0], feedback};

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      seeded    <= 1'b0;
      match     <= 1'b0;
      err       <= 1'b0;
      err_count <= '0;
    end else if (ttc_resync) begin
      match     <= 1'b0;
      err       <= 1'b0;
      err_count <= '0;
    end else if (!enable) begin
      seeded <= 1'b0;                             // Next enable reseeds
      match  <= 1'b0;
    end else if (frame_valid) begin
      if (!seeded) begin
        seeded <= 1'b1;                           // First frame is the seed
      end else if (frame_data == expected) begin
        match <= 1'b1;
        err   <= 1'b0;
      end else begin
        match <= 1'b0;
        err   <= 1'b1;
        if (err_count != '1) begin
          err_count <= err_count + 1'b1;
        end
      end
    end
  end

  // Compare against the received frame, not the predicted one
  always_ff @(posedge clock) begin
    if (enable && frame_valid) begin
      prev_frame <= frame_data;
    end
  end

  // Every flagged mismatch has been counted
  a_err_counted : assert property (
    @(posedge clock) disable iff (gtx_rx_reset) err |-> (err_count != '0)
  );

endmodule

`default_nettype wire

/* hw/gtx_optical_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module gtx_optical_rx import optical_rx_pkg::*; #(
  parameter bit POL_SWAP    = 1'b0,
  parameter int LT_PERIOD   = DEFAULT_LT_PERIOD,
  parameter int GOOD_FRAMES = DEFAULT_GOOD_FRAMES
) (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  logic                   ttc_resync,      // Clears link status and counters
  input  word_t                  rx_word,
  input  logic                   rx_kflag,
  input  logic                   en_prbs_test,
  input  logic [3:0]             delay_is,
  output logic                   gtx_rx_strobe,
  output logic                   gtx_rx_start,
  output logic                   gtx_rx_fc,
  output logic                   gtx_rx_match,
  output logic                   gtx_rx_err,
  output frame_data_t            gtx_rx_data,
  output frame_kchar_t           gtx_rx_kchar,
  output logic [ERR_COUNT_W-1:0] gtx_rx_err_count,
  output logic                   link_had_err,
  output logic                   link_good,
  output logic                   link_bad
);

  localparam int LT_W = $clog2(LT_PERIOD + 1);

  logic                   frame_valid;
  logic                   link_error;
  logic                   locked;
  frame_data_t            frame_data;
  frame_kchar_t           frame_kchar;
  logic [ERR_COUNT_W-1:0] link_errcount;
  logic [ERR_COUNT_W-1:0] prbs_errcount;
  logic                   force_error;            // Latency trigger out of step
  logic                   is_fc;
  logic                   lt_expect;              // FC due on this frame
  logic                   lt_seen;                // First FC seen since lock
  logic [LT_W-1:0]        lt_cnt;                 // Frames since the last FC
  logic                   ignore_link;
  frame_data_t            dly_data_in;
  frame_kchar_t           dly_kchar_in;

  //----------------------------------------------------------------------
  // Frame alignment, link health and PRBS test
  //----------------------------------------------------------------------
  frame_assembler #(.POL_SWAP(POL_SWAP)) u_frame_assembler (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .rx_word      (rx_word),
    .rx_kflag     (rx_kflag),
    .frame_valid  (frame_valid),
    .link_error   (link_error),
    .frame_data   (frame_data),
    .frame_kchar  (frame_kchar),
    .locked       (locked)
  );

  link_monitor #(.GOOD_FRAMES(GOOD_FRAMES)) u_link_monitor (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .ttc_resync   (ttc_resync),
    .frame_valid  (frame_valid),
    .link_error   (link_error),
    .force_error  (force_error),
    .errcount     (link_errcount),
    .link_had_err (link_had_err),
    .link_good    (link_good),
    .link_bad     (link_bad)
  );

  prbs_checker u_prbs_checker (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset),
    .ttc_resync   (ttc_resync),
    .enable       (en_prbs_test),
    .frame_valid  (frame_valid),
    .frame_data   (frame_data),
    .match        (gtx_rx_match),
    .err          (gtx_rx_err),
    .err_count    (prbs_errcount)
  );

  assign gtx_rx_err_count = en_prbs_test ? prbs_errcount : link_errcount;

  //----------------------------------------------------------------------
  // Latency trigger check
  //----------------------------------------------------------------------
  assign is_fc     = (frame_kchar == HDR_FC);
  assign lt_expect = (lt_cnt == LT_W'(LT_PERIOD));

  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      lt_cnt      <= '0;
      lt_seen     <= 1'b0;
      force_error <= 1'b0;
    end else begin
      force_error <= 1'b0;
      if (ttc_resync || !locked) begin            // A dropped frame breaks the count
        lt_cnt  <= '0;
        lt_seen <= 1'b0;
      end else if (frame_valid) begin
        if (is_fc || lt_expect) begin
          lt_cnt <= LT_W'(1);                     // Missing FC keeps the old cadence
        end else begin
          lt_cnt <= lt_cnt + 1'b1;
        end
        if (is_fc) begin
          lt_seen <= 1'b1;
        end
        if (lt_seen && (is_fc != lt_expect)) begin
          force_error <= 1'b1;                    // Early, extra or missing FC
        end
      end
    end
  end

  //----------------------------------------------------------------------
  // Bad link zeroing and output delay
  //----------------------------------------------------------------------
  assign ignore_link  = !link_good || link_bad;   // Keep bad links out of the triads
  assign dly_data_in  = ignore_link ? '0 : frame_data;
  assign dly_kchar_in = ignore_link ? '0 : frame_kchar;

  bx_delay_line #(.payload_t(frame_data_t)) u_data_delay (
    .clock    (clock),
    .shift_en (frame_valid),
    .delay_is (delay_is),
    .din      (dly_data_in),
    .dout     (gtx_rx_data)
  );

  bx_delay_line #(.payload_t(frame_kchar_t)) u_kchar_delay (
    .clock    (clock),
    .shift_en (frame_valid),
    .delay_is (delay_is),
    .din      (dly_kchar_in),
    .dout     (gtx_rx_kchar)
  );

  // Strobe and header flags follow the undelayed frame
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      gtx_rx_strobe <= 1'b0;
      gtx_rx_start  <= 1'b0;
      gtx_rx_fc     <= 1'b0;
    end else begin
      gtx_rx_strobe <= frame_valid;
      gtx_rx_start  <= frame_valid && (frame_kchar == HDR_START);
      gtx_rx_fc     <= frame_valid && is_fc;
    end
  end

endmodule

`default_nettype wire

/* hw/dcfeb_rx_array.sv */
`timescale 1ns/1ps
`default_nettype none

module dcfeb_rx_array import optical_rx_pkg::*; #(
  parameter int                  N_FIBERS    = 2,
  parameter int                  LT_PERIOD   = DEFAULT_LT_PERIOD,
  parameter int                  GOOD_FRAMES = DEFAULT_GOOD_FRAMES,
  parameter logic [N_FIBERS-1:0] POL_SWAP    = '0  // One bit per fiber
) (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  logic                   ttc_resync,
  input  logic                   en_prbs_test,
  input  logic [3:0]             delay_is,
  input  word_t                  rx_word          [N_FIBERS],
  input  logic [N_FIBERS-1:0]    rx_kflag,
  output logic [N_FIBERS-1:0]    gtx_rx_strobe,
  output logic [N_FIBERS-1:0]    gtx_rx_start,
  output logic [N_FIBERS-1:0]    gtx_rx_fc,
  output logic [N_FIBERS-1:0]    gtx_rx_match,
  output logic [N_FIBERS-1:0]    gtx_rx_err,
  output frame_data_t            gtx_rx_data      [N_FIBERS],
  output frame_kchar_t           gtx_rx_kchar     [N_FIBERS],
  output logic [ERR_COUNT_W-1:0] gtx_rx_err_count [N_FIBERS],
  output logic [N_FIBERS-1:0]    link_had_err,
  output logic [N_FIBERS-1:0]    link_good,
  output logic [N_FIBERS-1:0]    link_bad
);

  // One receiver per DCFEB fiber
  for (genvar i = 0; i < N_FIBERS; i++) begin : g_fiber
    gtx_optical_rx #(
      .POL_SWAP    (POL_SWAP[i]),
      .LT_PERIOD   (LT_PERIOD),
      .GOOD_FRAMES (GOOD_FRAMES)
    ) u_rx (
      .clock            (clock),
      .gtx_rx_reset     (gtx_rx_reset),
      .ttc_resync       (ttc_resync),
      .rx_word          (rx_word[i]),
      .rx_kflag         (rx_kflag[i]),
      .en_prbs_test     (en_prbs_test),
      .delay_is         (delay_is),
      .gtx_rx_strobe    (gtx_rx_strobe[i]),
      .gtx_rx_start     (gtx_rx_start[i]),
      .gtx_rx_fc        (gtx_rx_fc[i]),
      .gtx_rx_match     (gtx_rx_match[i]),
      .gtx_rx_err       (gtx_rx_err[i]),
      .gtx_rx_data      (gtx_rx_data[i]),
      .gtx_rx_kchar     (gtx_rx_kchar[i]),
      .gtx_rx_err_count (gtx_rx_err_count[i]),
      .link_had_err     (link_had_err[i]),
      .link_good        (link_good[i]),
      .link_bad         (link_bad[i])
    );
  end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,                 // Clock period
  parameter int RESET_CYCLES = 4                  // Rising edges with reset held
) (
  output logic clock,
  output logic gtx_rx_reset
);

  initial begin
    clock        = 1'b0;
    gtx_rx_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 gtx_rx_reset = 1'b0;                       // Release away from the edge
  end

  always #(PERIOD_NS / 2.0) clock = ~clock;

endmodule

`default_nettype wire

/* tb/tb_dcfeb_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcfeb_rx import optical_rx_pkg::*; ();

  localparam int N_FIBERS    = 2;
  localparam int LT_PERIOD   = 8;
  localparam int GOOD_FRAMES = 4;

  typedef struct packed {
    frame_data_t  data;
    frame_kchar_t kchar;
    logic         data_ok;                        // Delay line filled past the tap
    logic         start;
    logic         fc;
    logic         good;
    logic         bad;
    logic         had;
    logic         match;
    logic         err;
    logic [15:0]  cnt;
  } exp_t;

  logic                   clock;
  logic                   gtx_rx_reset;
  logic                   ttc_resync;
  logic                   en_prbs_test;
  logic [3:0]             delay_is;
  word_t                  rx_word          [N_FIBERS];
  logic [N_FIBERS-1:0]    rx_kflag;
  logic [N_FIBERS-1:0]    gtx_rx_strobe;
  logic [N_FIBERS-1:0]    gtx_rx_start;
  logic [N_FIBERS-1:0]    gtx_rx_fc;
  logic [N_FIBERS-1:0]    gtx_rx_match;
  logic [N_FIBERS-1:0]    gtx_rx_err;
  frame_data_t            gtx_rx_data      [N_FIBERS];
  frame_kchar_t           gtx_rx_kchar     [N_FIBERS];
  logic [ERR_COUNT_W-1:0] gtx_rx_err_count [N_FIBERS];
  logic [N_FIBERS-1:0]    link_had_err;
  logic [N_FIBERS-1:0]    link_good;
  logic [N_FIBERS-1:0]    link_bad;

  int          mismatches;
  int          other_errs;
  exp_t        exp_q [$];                         // One entry per expected strobe
  byte         cmd_q [$];
  int          val_q [$];
  bit          loaded;
  int          frame_idx;                         // Stimulus frame number for the FC cadence
  frame_data_t lfsr;
  bit          pend_resync;
  logic        pend_en;
  logic [3:0]  pend_delay;

  // Reference model state shared by both fibers
  logic [15:0]  m_link_cnt;
  logic [15:0]  m_prbs_cnt;
  logic         m_good;
  int           m_good_cnt;
  logic         m_had;
  int           m_lt_cnt;
  logic         m_lt_seen;
  logic         m_en;
  logic         m_seeded;
  frame_data_t  m_prev;
  logic         m_match;
  logic         m_err;
  int           m_delay;
  int           m_shifts;
  frame_data_t  m_dly_data  [16];
  frame_kchar_t m_dly_kchar [16];

  tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(4)) u_clock_gen (
    .clock        (clock),
    .gtx_rx_reset (gtx_rx_reset)
  );

  dcfeb_rx_array #(
    .N_FIBERS    (N_FIBERS),
    .LT_PERIOD   (LT_PERIOD),
    .GOOD_FRAMES (GOOD_FRAMES),
    .POL_SWAP    (2'b10)                          // Fiber 1 has the swapped route
  ) UUT (
    .clock            (clock),
    .gtx_rx_reset     (gtx_rx_reset),
    .ttc_resync       (ttc_resync),
    .en_prbs_test     (en_prbs_test),
    .delay_is         (delay_is),
    .rx_word          (rx_word),
    .rx_kflag         (rx_kflag),
    .gtx_rx_strobe    (gtx_rx_strobe),
    .gtx_rx_start     (gtx_rx_start),
    .gtx_rx_fc        (gtx_rx_fc),
    .gtx_rx_match     (gtx_rx_match),
    .gtx_rx_err       (gtx_rx_err),
    .gtx_rx_data      (gtx_rx_data),
    .gtx_rx_kchar     (gtx_rx_kchar),
    .gtx_rx_err_count (gtx_rx_err_count),
    .link_had_err     (link_had_err),
    .link_good        (link_good),
    .link_bad         (link_bad)
  );

  //----------------------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------------------
  function automatic frame_data_t lfsr_next(input frame_data_t s);
    return {s[46:0], s[47] ^ s[46] ^ s[20] ^ s[19]};  // Taps 48 47 21 20
  endfunction

  task automatic drive_word(input word_t w, input logic k);
    rx_word[0]  = w;
    rx_kflag[0] = k;
    rx_word[1]  = ~w;                             // Board route inverts fiber 1
    rx_kflag[1] = ~k;
  endtask

  task automatic next_header(output frame_kchar_t hdr);
    hdr = ((frame_idx % LT_PERIOD) == 0) ? HDR_FC : HDR_START;
    frame_idx++;
  endtask

  task automatic count_link_error();
    if (m_link_cnt != 16'hffff) m_link_cnt++;     // Saturates
    m_had      = 1'b1;
    m_good     = 1'b0;
    m_good_cnt = 0;
  endtask

  task automatic compare_field(input int fiber, input string name,
                               input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      mismatches++;
      $display("Mismatch at %0t: fiber %0d %s is %h, expected %h",
               $time, fiber, name, got, want);
    end
  endtask

  //----------------------------------------------------------------------
  // Reference model called once per good frame
  //----------------------------------------------------------------------
  task automatic model_frame(input frame_kchar_t hdr, input frame_data_t data);
    exp_t e;
    logic ignore;
    logic is_fc;
    logic due;
    logic force_err;
    ignore = !m_good || (m_link_cnt >= 16'd8);    // Zeros while link not usable
    for (int i = 15; i > 0; i--) begin
      m_dly_data[i]  = m_dly_data[i-1];
      m_dly_kchar[i] = m_dly_kchar[i-1];
    end
    m_dly_data[0]  = ignore ? '0 : data;
    m_dly_kchar[0] = ignore ? '0 : hdr;
    m_shifts++;
    if (!m_good) begin                            // Clean frame toward link good
      if (m_good_cnt == GOOD_FRAMES - 1) m_good = (m_link_cnt < 16'd8);
      else m_good_cnt++;
    end
    if (m_en) begin
      if (!m_seeded) m_seeded = 1'b1;             // First frame seeds the test
      else if (data == lfsr_next(m_prev)) begin
        m_match = 1'b1;
        m_err   = 1'b0;
      end else begin
        m_match = 1'b0;
        m_err   = 1'b1;
        if (m_prbs_cnt != 16'hffff) m_prbs_cnt++;
      end
      m_prev = data;
    end
    e.data    = m_dly_data[m_delay];
    e.kchar   = m_dly_kchar[m_delay];
    e.data_ok = (m_shifts > m_delay);
    e.start   = (hdr == HDR_START);
    e.fc      = (hdr == HDR_FC);
    e.good    = m_good;
    e.bad     = (m_link_cnt >= 16'd8);
    e.had     = m_had;
    e.match   = m_match;
    e.err     = m_err;
    e.cnt     = m_en ? m_prbs_cnt : m_link_cnt;
    exp_q.push_back(e);
    // FC due exactly LT_PERIOD frames after the previous one
    is_fc     = (hdr == HDR_FC);
    due       = (m_lt_cnt == LT_PERIOD);
    force_err = m_lt_seen && (is_fc != due);
    m_lt_cnt  = (is_fc || due) ? 1 : m_lt_cnt + 1;
    if (is_fc) m_lt_seen = 1'b1;
    if (force_err) count_link_error();            // Seen after this strobe
  endtask

  task automatic send_frame(input frame_kchar_t hdr, input frame_data_t data, input bit bad);
    bit do_resync;
    @(posedge clock);
    #1 drive_word(hdr, 1'b1);
    @(posedge clock);
    #1 drive_word(data[47:32], bad);              // Bad frame carries a K flag here
    @(posedge clock);
    #1 drive_word(data[31:16], 1'b0);
    do_resync    = pend_resync;
    ttc_resync   = pend_resync;                   // Controls change mid frame
    en_prbs_test = pend_en;
    delay_is     = pend_delay;
    pend_resync  = 1'b0;
    @(posedge clock);
    #1 drive_word(data[15:0], 1'b0);
    ttc_resync = 1'b0;
    if (do_resync) begin
      m_link_cnt = '0;
      m_prbs_cnt = '0;
      m_had      = 1'b0;
      m_good     = 1'b0;
      m_good_cnt = 0;
      m_lt_cnt   = 0;
      m_lt_seen  = 1'b0;
      m_match    = 1'b0;
      m_err      = 1'b0;
    end
    if (!pend_en) begin
      m_seeded = 1'b0;
      m_match  = 1'b0;
    end
    m_en    = pend_en;
    m_delay = pend_delay;
    if (bad) begin                                // Assembler drops to hunt
      count_link_error();
      m_lt_cnt  = 0;
      m_lt_seen = 1'b0;
    end else begin
      model_frame(hdr, data);
    end
  endtask

  task automatic send_random(input int n);
    frame_kchar_t hdr;
    for (int i = 0; i < n; i++) begin
      next_header(hdr);
      send_frame(hdr, {$urandom(), $urandom()}, 1'b0);
    end
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin
    int          fd;
    int          v;
    byte         c;
    string       line;
    frame_kchar_t hdr;
    v = $urandom(32'h53a5cd88);                   // Seed once
    mismatches = 0;
    other_errs = 0;
    ttc_resync = 1'b0;
    en_prbs_test = 1'b0;
    delay_is = '0;
    drive_word('0, 1'b0);
    pend_resync = 1'b0;
    pend_en = 1'b0;
    pend_delay = '0;
    frame_idx = 0;
    m_link_cnt = '0;
    m_prbs_cnt = '0;
    m_good = 1'b0;
    m_good_cnt = 0;
    m_had = 1'b0;
    m_lt_cnt = 0;
    m_lt_seen = 1'b0;
    m_en = 1'b0;
    m_seeded = 1'b0;
    m_prev = '0;
    m_match = 1'b0;
    m_err = 1'b0;
    m_delay = 0;
    m_shifts = 0;
    for (int i = 0; i < 16; i++) begin
      m_dly_data[i]  = '0;
      m_dly_kchar[i] = '0;
    end
    lfsr = {$urandom(), $urandom()};
    fd = $fopen("tb/rx_input.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Could not open the stimulus file tb/rx_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
          v = 0;
          void'($sscanf(line, "%c %d", c, v));
          cmd_q.push_back(c);
          val_q.push_back(v);
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    @(negedge gtx_rx_reset);
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "F": send_random(val_q[i]);
        "B": begin                                // K flag in a data word
          next_header(hdr);
          send_frame(hdr, {$urandom(), $urandom()}, 1'b1);
        end
        "M": begin                                // Replace the next FC by START
          send_random((LT_PERIOD - (frame_idx % LT_PERIOD)) % LT_PERIOD);
          frame_idx++;
          send_frame(HDR_START, {$urandom(), $urandom()}, 1'b0);
        end
        "Q": for (int k = 0; k < val_q[i]; k++) begin
          next_header(hdr);
          send_frame(hdr, lfsr, 1'b0);
          lfsr = lfsr_next(lfsr);
        end
        "X": begin                                // One corrupted PRBS frame
          next_header(hdr);
          send_frame(hdr, lfsr ^ 48'h1, 1'b0);
          lfsr = lfsr_next(lfsr ^ 48'h1);
        end
        "P": pend_en = (val_q[i] != 0);
        "D": pend_delay = val_q[i][3:0];
        "R": pend_resync = 1'b1;
        "E": begin
          assert ((m_en ? m_prbs_cnt : m_link_cnt) == val_q[i]) else begin
            mismatches++;
            $display("Mismatch at %0t: error count checkpoint %0d, model has %0d",
                     $time, val_q[i], m_en ? m_prbs_cnt : m_link_cnt);
          end
        end
        default: begin
          other_errs++;
          $display("Unknown command in the stimulus file");
        end
      endcase
    end
    while (exp_q.size() != 0) @(posedge clock);   // Last strobes drain
    repeat (2) @(posedge clock);
    $display("Error counts: %0d mismatches, %0d other failures", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  //----------------------------------------------------------------------
  // Output checks at the falling edge
  //----------------------------------------------------------------------
  always @(negedge clock) begin
    exp_t e;
    if (!gtx_rx_reset) begin
      assert (gtx_rx_strobe[1] == gtx_rx_strobe[0]) else begin
        other_errs++;
        $display("The two fibers strobed in different cycles at %0t", $time);
      end
      if (gtx_rx_strobe[0]) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("A strobe arrived at %0t with no frame expected", $time);
        end else begin
          e = exp_q.pop_front();
          for (int f = 0; f < N_FIBERS; f++) begin
            if (e.data_ok) begin                  // Unfilled delay taps hold no value
              compare_field(f, "data", gtx_rx_data[f], e.data);
              compare_field(f, "kchar", gtx_rx_kchar[f], e.kchar);
            end
            compare_field(f, "start", gtx_rx_start[f], e.start);
            compare_field(f, "fc", gtx_rx_fc[f], e.fc);
            compare_field(f, "link_good", link_good[f], e.good);
            compare_field(f, "link_bad", link_bad[f], e.bad);
            compare_field(f, "link_had_err", link_had_err[f], e.had);
            compare_field(f, "match", gtx_rx_match[f], e.match);
            compare_field(f, "err", gtx_rx_err[f], e.err);
            compare_field(f, "err_count", gtx_rx_err_count[f], e.cnt);
          end
        end
      end
    end
  end

  // Watchdog sized from the command count
  initial begin
    wait (loaded);
    #(cmd_q.size() * 64 * 4 + 2000);
    $display("Watchdog timeout, the run did not finish in time");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/rx_input.txt */
# Commands: F n random frames, B frame with K in data, M missing FC, Q n PRBS frames,
# X corrupted PRBS frame, P en_prbs_test, D delay_is, R ttc_resync, E expected err count
F 12
E 0
D 3
F 10
D 0
F 1
B
F 2
E 1
F 4
R
F 6
E 0
F 16
E 0
M
F 1
E 1
M
M
M
M
M
M
M
F 2
E 8
R
F 8
P 1
Q 6
E 0
X
Q 2
E 1
P 0
F 2
E 0

/* compile.f */
hw/optical_rx_pkg.sv
hw/bx_delay_line.sv
hw/frame_assembler.sv
hw/link_monitor.sv
hw/prbs_checker.sv
hw/gtx_optical_rx.sv
hw/dcfeb_rx_array.sv
tb/tb_clock_gen.sv
tb/tb_dcfeb_rx.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_dcfeb_rx -o sim_tb

out=$(./obj_dir/sim_tb) || true
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
  exit 0
else
  exit 1
fi
